/* hw/gamePhysicsPkg.sv */
package gamePhysicsPkg;

   // Positions and velocities carry 10 pixel bits and 6 fraction bits.
   typedef logic [15:0] subpixelT;
   typedef logic [9:0] pixelT;
   typedef logic [6:0] tileT;
   typedef logic [6:0] brickAddrT;
   typedef logic [2:0] brickRowT;
   typedef logic [3:0] brickColT;

   // One sub-step walks through these phases in order.
   typedef enum logic [2:0] {
      extrapolate,
      locate,
      beginLoad,
      loadX,
      loadY,
      collide,
      update,
      storeY
   } physPhaseT;

   typedef enum logic [1:0] {
      waitRelease,
      inGame,
      lost
   } ballStateT;

   localparam pixelT ballSizePixel = 10'd8;
   localparam pixelT paddleLengthPixel = 10'd56;

   // The paddle top sits on a tile boundary.
   localparam tileT paddleYTile = 7'd70;
   localparam pixelT paddleYPixel = pixelT'(paddleYTile) * 10'd8;

   localparam tileT leftWallXTile = 7'd1;
   localparam tileT rightWallXTile = 7'd98;
   localparam tileT ceilingYTile = 7'd2;

   // Paddle range, end is exclusive.
   localparam pixelT gameBeginXPixel = pixelT'(leftWallXTile + 7'd1) * 10'd8;
   localparam pixelT gameEndXPixel = pixelT'(rightWallXTile) * 10'd8;

   // A brick is 8 tiles wide and 2 tiles tall.
   localparam tileT brickStartXTile = 7'd2;
   localparam tileT brickStartYTile = 7'd8;
   localparam int brickColCount = 12;
   localparam int brickRowCount = 6;
   localparam int brickCount = brickColCount * brickRowCount;
   localparam brickAddrT invalidBrick = brickAddrT'(brickCount);

   localparam subpixelT paddleSpeedSubpixel = 16'd48;
   localparam int stepsPerFrame = 12;

   localparam subpixelT paddleHomeX = {10'd370, 6'd0};
   localparam subpixelT ballHomeY = subpixelT'(paddleYPixel - ballSizePixel) << 6;
   localparam subpixelT releaseVelX = 16'd8;
   localparam subpixelT releaseVelY = 16'hfff0;

endpackage

/* hw/ballMotionIf.sv */
interface ballMotionIf;
   import gamePhysicsPkg::*;

   subpixelT ballX;
   subpixelT ballY;
   subpixelT velX;
   subpixelT velY;

   // Sign bits of the velocity.
   logic goesLeft;
   logic goesUp;

   modport owner (
      output ballX, ballY, velX, velY, goesLeft, goesUp
   );

   modport viewer (
      input ballX, ballY, velX, velY, goesLeft, goesUp
   );

endinterface

/* hw/brickStore.sv */
module brickStore (
   input logic CLK,
   input logic RESET,
   input gamePhysicsPkg::brickAddrT addr,
   input logic writeData,
   input logic writeEnable,
   input gamePhysicsPkg::brickAddrT readAddr,
   output logic readData,
   output logic readAlive
);
   import gamePhysicsPkg::*;

   // One alive bit per brick, plus the dummy entry that always reads zero.
   logic [brickCount:0] alive;

   always_ff @(posedge CLK) begin
      if (RESET) begin
         alive <= {1'b0, {brickCount{1'b1}}};
      end else if (writeEnable && addr < invalidBrick) begin
         alive[addr] <= writeData;
      end
   end

   // Physics port.
   always_ff @(posedge CLK) begin
      readData <= (addr <= invalidBrick) ? alive[addr] : 1'b0;
   end

   // Display port, read only.
   always_ff @(posedge CLK) begin
      readAlive <= (readAddr <= invalidBrick) ? alive[readAddr] : 1'b0;
   end

endmodule

/* hw/stepSequencer.sv */
module stepSequencer (
   input logic CLK,
   input logic RESET,
   input logic startUpdate,
   input gamePhysicsPkg::brickAddrT nbrXAddr,
   input gamePhysicsPkg::brickAddrT nbrYAddr,
   output gamePhysicsPkg::physPhaseT phase,
   output logic stepComplete,
   output gamePhysicsPkg::brickAddrT storeAddr,
   output logic storeWrite
);
   import gamePhysicsPkg::*;

   // Sub-steps done in this frame. The last value doubles as idle.
   logic [3:0] stepCount;

   always_ff @(posedge CLK) begin
      if (RESET) begin
         phase <= extrapolate;
         stepCount <= 4'(stepsPerFrame - 1);
         stepComplete <= 1'b0;
      end else begin
         stepComplete <= (phase == update);
         case (phase)
            extrapolate: begin
               if (stepCount == 4'(stepsPerFrame - 1)) begin
                  // Idle until a new frame is requested.
                  if (startUpdate) begin
                     stepCount <= 4'd0;
                     phase <= locate;
                  end
               end else begin
                  stepCount <= stepCount + 4'd1;
                  phase <= locate;
               end
            end
            storeY: begin
               phase <= extrapolate;
            end
            default: begin
               phase <= physPhaseT'(phase + 3'd1);
            end
         endcase
      end
   end

   // The store answers one cycle after the address, so each load is
   // addressed one phase ahead of its latch.
   always_comb begin
      case (phase)
         beginLoad,
         update: storeAddr = nbrXAddr;
         loadX,
         storeY: storeAddr = nbrYAddr;
         default: storeAddr = invalidBrick;
      endcase
   end

   // Write back both neighbor alive bits after the collision.
   assign storeWrite = (phase == update) || (phase == storeY);

endmodule

/* hw/tileLocator.sv */
module tileLocator (
   input logic CLK,
   input gamePhysicsPkg::physPhaseT phase,
   ballMotionIf.viewer ball,
   output gamePhysicsPkg::brickAddrT nbrXAddr,
   output gamePhysicsPkg::brickAddrT nbrYAddr,
   output logic canHitX,
   output logic canHitY,
   output logic inBrickArea,
   output gamePhysicsPkg::brickRowT curRow,
   output logic lostLine
);
   import gamePhysicsPkg::*;

   tileT ballXTile;
   tileT ballYTile;
   pixelT endXPixel;
   pixelT endYPixel;
   logic atTileX;
   logic atTileY;

   // Tiles of the brick the ball currently occupies.
   tileT cXTile;
   tileT cYTile;

   tileT xOffset;
   tileT yOffset;
   brickColT col;
   brickRowT row;
   logic rowValid;
   logic aboveFirstRow;
   logic beneathLastRow;
   logic areaHit;

   function automatic brickAddrT brickIndex(input brickRowT r, input brickColT c);
      return brickAddrT'(int'(r) * brickColCount + int'(c));
   endfunction

   assign ballXTile = ball.ballX[15:9];
   assign ballYTile = ball.ballY[15:9];
   assign endXPixel = ball.ballX[15:6] + ballSizePixel - 10'd1;
   assign endYPixel = ball.ballY[15:6] + ballSizePixel - 10'd1;
   assign atTileX = (ball.ballX[8:0] == 9'd0);
   assign atTileY = (ball.ballY[8:0] == 9'd0);

   always_ff @(posedge CLK) begin
      if (phase == extrapolate) begin
         if (ball.goesLeft) begin
            cXTile <= endXPixel[9:3];
            canHitX <= atTileX && (ballXTile[2:0] == brickStartXTile[2:0]);
         end else begin
            cXTile <= ballXTile;
            canHitX <= atTileX && ((ballXTile[2:0] + 3'd1) == brickStartXTile[2:0]);
         end
         if (ball.goesUp) begin
            cYTile <= endYPixel[9:3];
            canHitY <= atTileY && (ballYTile[0] == brickStartYTile[0]);
         end else begin
            cYTile <= ballYTile;
            canHitY <= atTileY && (ballYTile[0] != brickStartYTile[0]);
         end
      end
   end

   assign xOffset = cXTile - brickStartXTile;
   assign yOffset = cYTile - brickStartYTile;
   assign col = xOffset[6:3];
   assign row = yOffset[3:1];

   // Just outside the grid the ball can still touch the first or last row.
   assign rowValid = (yOffset[6:1] < brickRowCount);
   assign aboveFirstRow = (&yOffset) && !ball.goesUp;
   assign beneathLastRow = (yOffset == tileT'(2 * brickRowCount)) && ball.goesUp;
   assign areaHit = rowValid || aboveFirstRow || beneathLastRow;

   always_ff @(posedge CLK) begin
      if (phase == locate) begin
         inBrickArea <= areaHit;
         curRow <= row;
         lostLine <= (ballYTile == paddleYTile + 7'd3);

         if (!rowValid) begin
            nbrXAddr <= invalidBrick;
         end else if (ball.goesLeft) begin
            nbrXAddr <= (col == 4'd0) ? invalidBrick : brickIndex(row, col - 4'd1);
         end else begin
            nbrXAddr <= (col == 4'(brickColCount - 1)) ? invalidBrick :
               brickIndex(row, col + 4'd1);
         end

         // Row above the grid wraps to 7, so its lower neighbor is row 0.
         if (!areaHit) begin
            nbrYAddr <= invalidBrick;
         end else if (ball.goesUp) begin
            nbrYAddr <= (row == 3'd0) ? invalidBrick : brickIndex(row - 3'd1, col);
         end else begin
            nbrYAddr <= (row == 3'(brickRowCount - 1)) ? invalidBrick :
               brickIndex(row + 3'd1, col);
         end
      end
   end

endmodule

/* hw/collisionResolver.sv */
module collisionResolver (
   input logic CLK,
   input logic RESET,
   input gamePhysicsPkg::physPhaseT phase,
   ballMotionIf.viewer ball,
   input logic canHitX,
   input logic canHitY,
   input logic inBrickArea,
   input gamePhysicsPkg::brickRowT curRow,
   input logic brickData,
   input gamePhysicsPkg::pixelT paddleXPixel,
   input logic ballWaiting,
   output gamePhysicsPkg::subpixelT newVelX,
   output gamePhysicsPkg::subpixelT newVelY,
   output logic nbrXAlive,
   output logic nbrYAlive,
   output logic hitWall,
   output logic hitPaddle,
   output logic hitBrick,
   output gamePhysicsPkg::brickRowT hitBrickRow
);
   import gamePhysicsPkg::*;

   tileT ballXTile;
   tileT ballYTile;
   logic atTileX;
   logic atTileY;
   pixelT ballEndXPixel;
   pixelT paddleOffset;
   logic sideWall;
   logic ceiling;
   logic paddleContact;
   logic hitXBrick;
   logic hitYBrick;
   brickRowT yRow;

   assign ballXTile = ball.ballX[15:9];
   assign ballYTile = ball.ballY[15:9];
   assign atTileX = (ball.ballX[8:0] == 9'd0);
   assign atTileY = (ball.ballY[8:0] == 9'd0);
   assign ballEndXPixel = ball.ballX[15:6] + ballSizePixel - 10'd1;

   assign sideWall = atTileX && (ball.goesLeft ?
      (ballXTile == leftWallXTile + 7'd1) : (ballXTile == rightWallXTile - 7'd1));
   assign ceiling = atTileY && ball.goesUp && (ballYTile == ceilingYTile + 7'd1);

   // Offset wraps negative when the ball is left of the paddle.
   assign paddleOffset = ballEndXPixel - paddleXPixel;
   assign paddleContact = atTileY && !ball.goesUp && !ballWaiting &&
      (ballYTile == paddleYTile - 7'd1) &&
      (paddleOffset < paddleLengthPixel + ballSizePixel - 10'd1);

   assign hitXBrick = inBrickArea && canHitX && nbrXAlive;
   assign hitYBrick = inBrickArea && canHitY && nbrYAlive;
   assign yRow = ball.goesUp ? curRow - 3'd1 : curRow + 3'd1;

   // Neighbor latches and the reflected velocity.
   always_ff @(posedge CLK) begin
      case (phase)
         loadX: nbrXAlive <= brickData;
         loadY: nbrYAlive <= brickData;
         collide: begin
            if (hitXBrick) begin
               nbrXAlive <= 1'b0;
            end
            if (hitYBrick) begin
               nbrYAlive <= 1'b0;
            end
            newVelX <= (sideWall || hitXBrick) ? -ball.velX : ball.velX;
            newVelY <= (paddleContact || ceiling || hitYBrick) ? -ball.velY : ball.velY;
         end
         default: ;
      endcase
   end

   // Flags stay up through update and the step-complete cycle.
   always_ff @(posedge CLK) begin
      if (RESET || phase == storeY) begin
         hitWall <= 1'b0;
         hitPaddle <= 1'b0;
         hitBrick <= 1'b0;
         hitBrickRow <= '0;
      end else if (phase == collide) begin
         hitWall <= sideWall || ceiling;
         hitPaddle <= paddleContact;
         hitBrick <= hitXBrick || hitYBrick;
         hitBrickRow <= hitYBrick ? yRow : (hitXBrick ? curRow : '0);
      end
   end

endmodule

/* hw/ballPaddleState.sv */
module ballPaddleState (
   input logic CLK,
   input logic RESET,
   input gamePhysicsPkg::physPhaseT phase,
   input logic btnLeft,
   input logic btnRight,
   input logic btnRelease,
   input logic ignoreDeath,
   input logic lostLine,
   input gamePhysicsPkg::subpixelT newVelX,
   input gamePhysicsPkg::subpixelT newVelY,
   ballMotionIf.owner ball,
   output gamePhysicsPkg::pixelT paddleXPixel,
   output logic ballWaiting,
   output logic ballLost
);
   import gamePhysicsPkg::*;

   ballStateT ballState;
   subpixelT paddleX;
   subpixelT newPaddleX;
   subpixelT movedX;
   subpixelT ballX;
   subpixelT ballY;
   subpixelT velX;
   subpixelT velY;
   pixelT centerXPixel;

   assign movedX = paddleX - (btnLeft ? paddleSpeedSubpixel : '0) +
      (btnRight ? paddleSpeedSubpixel : '0);

   // Tentative paddle position, clamped to the playfield.
   always_ff @(posedge CLK) begin
      if (phase == extrapolate) begin
         if (movedX < {gameBeginXPixel, 6'd0}) begin
            newPaddleX <= {gameBeginXPixel, 6'd0};
         end else if (movedX > {gameEndXPixel - paddleLengthPixel, 6'd0}) begin
            newPaddleX <= {gameEndXPixel - paddleLengthPixel, 6'd0};
         end else begin
            newPaddleX <= movedX;
         end
      end
   end

   // A waiting ball rides centered on the moved paddle.
   assign centerXPixel = newPaddleX[15:6] + (paddleLengthPixel - ballSizePixel) / 2;

   always_ff @(posedge CLK) begin
      if (RESET) begin
         ballState <= waitRelease;
         paddleX <= paddleHomeX;
         ballX <= {paddleHomeX[15:6] + (paddleLengthPixel - ballSizePixel) / 2, 6'd0};
         ballY <= ballHomeY;
         velX <= '0;
         velY <= '0;
         ballLost <= 1'b0;
      end else if (phase == update) begin
         paddleX <= newPaddleX;
         case (ballState)
            waitRelease: begin
               ballX <= {centerXPixel, 6'd0};
               ballY <= {paddleYPixel - ballSizePixel, 6'd0};
               if (btnRelease) begin
                  ballState <= inGame;
                  velX <= releaseVelX;
                  velY <= releaseVelY;
               end
            end
            inGame: begin
               ballX <= ballX + newVelX;
               ballY <= ballY + newVelY;
               velX <= newVelX;
               velY <= newVelY;
               if (lostLine && !ignoreDeath) begin
                  ballState <= lost;
                  ballLost <= 1'b1;
               end
            end
            default: begin
               // Ball gone, bring the paddle home for the next serve.
               paddleX <= paddleHomeX;
               velX <= '0;
               velY <= '0;
               ballState <= waitRelease;
            end
         endcase
      end else begin
         ballLost <= 1'b0;
      end
   end

   assign ball.ballX = ballX;
   assign ball.ballY = ballY;
   assign ball.velX = velX;
   assign ball.velY = velY;
   assign ball.goesLeft = velX[15];
   assign ball.goesUp = velY[15];

   assign paddleXPixel = paddleX[15:6];
   assign ballWaiting = (ballState == waitRelease);

endmodule

/* hw/gamePhysics.sv */
module gamePhysics (
   input logic CLK,
   input logic RESET,
   input logic startUpdate,
   input logic btnLeft,
   input logic btnRight,
   input logic btnRelease,
   input logic ignoreDeath,
   output logic stepComplete,
   output logic hitWall,
   output logic hitPaddle,
   output logic hitBrick,
   output gamePhysicsPkg::brickRowT hitBrickRow,
   output logic ballLost,
   output gamePhysicsPkg::pixelT paddleXPixel,
   output gamePhysicsPkg::pixelT ballXPixel,
   output gamePhysicsPkg::pixelT ballYPixel,
   input gamePhysicsPkg::brickAddrT brickAddr,
   output logic brickAlive
);
   import gamePhysicsPkg::*;

   physPhaseT phase;
   brickAddrT nbrXAddr;
   brickAddrT nbrYAddr;
   logic canHitX;
   logic canHitY;
   logic inBrickArea;
   brickRowT curRow;
   logic lostLine;
   brickAddrT storeAddr;
   logic storeWrite;
   logic storeData;
   logic brickData;
   subpixelT newVelX;
   subpixelT newVelY;
   logic nbrXAlive;
   logic nbrYAlive;
   logic ballWaiting;

   ballMotionIf ballBus ();

   stepSequencer u_stepSequencer (
      .CLK(CLK),
      .RESET(RESET),
      .startUpdate(startUpdate),
      .nbrXAddr(nbrXAddr),
      .nbrYAddr(nbrYAddr),
      .phase(phase),
      .stepComplete(stepComplete),
      .storeAddr(storeAddr),
      .storeWrite(storeWrite)
   );

   tileLocator u_tileLocator (
      .CLK(CLK),
      .phase(phase),
      .ball(ballBus),
      .nbrXAddr(nbrXAddr),
      .nbrYAddr(nbrYAddr),
      .canHitX(canHitX),
      .canHitY(canHitY),
      .inBrickArea(inBrickArea),
      .curRow(curRow),
      .lostLine(lostLine)
   );

   // X neighbor is written back in update, Y neighbor in storeY.
   assign storeData = (phase == storeY) ? nbrYAlive : nbrXAlive;

   brickStore u_brickStore (
      .CLK(CLK),
      .RESET(RESET),
      .addr(storeAddr),
      .writeData(storeData),
      .writeEnable(storeWrite),
      .readAddr(brickAddr),
      .readData(brickData),
      .readAlive(brickAlive)
   );

   collisionResolver u_collisionResolver (
      .CLK(CLK),
      .RESET(RESET),
      .phase(phase),
      .ball(ballBus),
      .canHitX(canHitX),
      .canHitY(canHitY),
      .inBrickArea(inBrickArea),
      .curRow(curRow),
      .brickData(brickData),
      .paddleXPixel(paddleXPixel),
      .ballWaiting(ballWaiting),
      .newVelX(newVelX),
      .newVelY(newVelY),
      .nbrXAlive(nbrXAlive),
      .nbrYAlive(nbrYAlive),
      .hitWall(hitWall),
      .hitPaddle(hitPaddle),
      .hitBrick(hitBrick),
      .hitBrickRow(hitBrickRow)
   );

   ballPaddleState u_ballPaddleState (
      .CLK(CLK),
      .RESET(RESET),
      .phase(phase),
      .btnLeft(btnLeft),
      .btnRight(btnRight),
      .btnRelease(btnRelease),
      .ignoreDeath(ignoreDeath),
      .lostLine(lostLine),
      .newVelX(newVelX),
      .newVelY(newVelY),
      .ball(ballBus),
      .paddleXPixel(paddleXPixel),
      .ballWaiting(ballWaiting),
      .ballLost(ballLost)
   );

   assign ballXPixel = ballBus.ballX[15:6];
   assign ballYPixel = ballBus.ballY[15:6];

endmodule

/* test/physicsChecker.sv */
module physicsChecker (
   input logic CLK,
   input logic RESET,
   input logic startUpdate,
   input logic btnLeft,
   input logic btnRight,
   input logic btnRelease,
   input logic ignoreDeath,
   input logic stepComplete,
   input logic hitWall,
   input logic hitPaddle,
   input logic hitBrick,
   input gamePhysicsPkg::brickRowT hitBrickRow,
   input logic ballLost,
   input gamePhysicsPkg::pixelT paddleXPixel,
   input gamePhysicsPkg::pixelT ballXPixel,
   input gamePhysicsPkg::pixelT ballYPixel,
   input gamePhysicsPkg::brickAddrT brickAddr,
   input logic brickAlive,
   input logic sweepDone,
   output int mismatchCount,
   output int failureCount
);
   timeunit 1ns;
   timeprecision 1ps;
   import gamePhysicsPkg::*;

   // Brick hits leave the axis open, so a few candidate balls are tracked.
   subpixelT cx [8];
   subpixelT cy [8];
   subpixelT cvx [8];
   subpixelT cvy [8];
   int cn;
   subpixelT padX;
   ballStateT st;
   logic busy;
   int cyc;
   int stepNo;
   int totalSteps;
   int frameHits;
   int prevCount;
   logic firstSweep;
   logic image [brickCount];
   brickAddrT lastAddr;

   // Ball touching the inner face of the wall it moves toward.
   function automatic logic sideWallAt(input subpixelT x, input subpixelT vx);
      return vx[15] ? (x == {gameBeginXPixel, 6'd0}) :
         (x == {gameEndXPixel - ballSizePixel, 6'd0});
   endfunction

   function automatic logic ceilingAt(input subpixelT y, input subpixelT vy);
      return vy[15] && (y == {pixelT'(ceilingYTile) * 10'd8 + 10'd8, 6'd0});
   endfunction

   // Ball resting on the paddle top and overlapping it horizontally.
   function automatic logic paddleAt(input subpixelT x, input subpixelT y,
      input subpixelT vy, input pixelT pad);
      int left;
      left = int'(x[15:6]);
      return !vy[15] && (y == {paddleYPixel - ballSizePixel, 6'd0}) &&
         (left + int'(ballSizePixel) > int'(pad)) &&
         (left < int'(pad) + int'(paddleLengthPixel));
   endfunction

   // Bricks are two tiles tall, counted from the top of the brick area.
   function automatic brickRowT rowOfTile(input tileT t);
      tileT offset;
      offset = t - brickStartYTile;
      return brickRowT'(offset >> 1);
   endfunction

   task automatic checkStep();
      subpixelT moved;
      subpixelT newPad;
      subpixelT nx;
      subpixelT ny;
      subpixelT nvx;
      subpixelT nvy;
      subpixelT tx [8];
      subpixelT ty [8];
      subpixelT tvx [8];
      subpixelT tvy [8];
      int tn;
      logic side;
      logic ceil;
      logic pad;
      logic lostE;
      logic dup;
      logic rowOk;
      tileT bottomTile;
      pixelT expPad;
      pixelT centerX;
      tn = 0;
      moved = padX - (btnLeft ? paddleSpeedSubpixel : 16'd0) +
         (btnRight ? paddleSpeedSubpixel : 16'd0);
      if (moved < {gameBeginXPixel, 6'd0}) begin
         newPad = {gameBeginXPixel, 6'd0};
      end else if (moved > {gameEndXPixel - paddleLengthPixel, 6'd0}) begin
         newPad = {gameEndXPixel - paddleLengthPixel, 6'd0};
      end else begin
         newPad = moved;
      end
      expPad = (st == lost) ? paddleHomeX[15:6] : newPad[15:6];
      if (paddleXPixel !== expPad) begin
         mismatchCount++;
         $display("Mismatch paddle step %0d: expected %0d, actual %0d",
            totalSteps, expPad, paddleXPixel);
      end
      centerX = newPad[15:6] + (paddleLengthPixel - ballSizePixel) / 2;
      for (int i = 0; i < cn; i++) begin
         side = sideWallAt(cx[i], cvx[i]);
         ceil = ceilingAt(cy[i], cvy[i]);
         pad = (st != waitRelease) && paddleAt(cx[i], cy[i], cvy[i], padX[15:6]);
         lostE = (st == inGame) && (cy[i][15:9] == paddleYTile + 7'd3) && !ignoreDeath;
         if ({hitWall, hitPaddle, ballLost} === {side || ceil, pad, lostE}) begin
            bottomTile = tileT'((cy[i][15:6] + ballSizePixel - 10'd1) >> 3);
            for (int f = 0; f < 4; f++) begin
               // Row of the brick that this hit combination points at.
               if (f[1]) begin
                  rowOk = (hitBrickRow === rowOfTile(cvy[i][15] ? cy[i][15:9] - 7'd1 :
                     cy[i][15:9] + 7'd1));
               end else if (f[0]) begin
                  rowOk = (hitBrickRow === rowOfTile(cy[i][15:9])) ||
                     (hitBrickRow === rowOfTile(bottomTile));
               end else begin
                  rowOk = (hitBrickRow === 3'd0);
               end
               if (rowOk && ((f != 0) == hitBrick) && (!f[0] || cx[i][8:0] == 9'd0) &&
                  (!f[1] || cy[i][8:0] == 9'd0)) begin
                  nvx = (side || f[0]) ? 16'd0 - cvx[i] : cvx[i];
                  nvy = (pad || ceil || f[1]) ? 16'd0 - cvy[i] : cvy[i];
                  case (st)
                     waitRelease: begin
                        nx = {centerX, 6'd0};
                        ny = {paddleYPixel - ballSizePixel, 6'd0};
                        nvx = btnRelease ? releaseVelX : cvx[i];
                        nvy = btnRelease ? releaseVelY : cvy[i];
                     end
                     inGame: begin
                        nx = cx[i] + nvx;
                        ny = cy[i] + nvy;
                     end
                     default: begin
                        nx = cx[i];
                        ny = cy[i];
                        nvx = '0;
                        nvy = '0;
                     end
                  endcase
                  dup = 1'b0;
                  for (int j = 0; j < tn; j++) begin
                     if (tx[j] == nx && ty[j] == ny && tvx[j] == nvx && tvy[j] == nvy) begin
                        dup = 1'b1;
                     end
                  end
                  if (!dup && tn < 8 && nx[15:6] == ballXPixel && ny[15:6] == ballYPixel) begin
                     tx[tn] = nx;
                     ty[tn] = ny;
                     tvx[tn] = nvx;
                     tvy[tn] = nvy;
                     tn++;
                  end
               end
            end
         end
      end
      if (tn == 0) begin
         mismatchCount++;
         $display("Mismatch ball step %0d: expected x %0d y %0d, actual x %0d y %0d",
            totalSteps, cx[0][15:6] + cvx[0][15:6], cy[0][15:6] + cvy[0][15:6],
            ballXPixel, ballYPixel);
         $display("   flags wall %b paddle %b brick %b row %0d lost %b", hitWall, hitPaddle,
            hitBrick, hitBrickRow, ballLost);
         // Resync on the observed pixels.
         tx[0] = {ballXPixel, 6'd0};
         ty[0] = {ballYPixel, 6'd0};
         tvx[0] = (st == waitRelease && btnRelease) ? releaseVelX : cvx[0];
         tvy[0] = (st == waitRelease && btnRelease) ? releaseVelY : cvy[0];
         tn = 1;
      end
      for (int i = 0; i < tn; i++) begin
         cx[i] = tx[i];
         cy[i] = ty[i];
         cvx[i] = tvx[i];
         cvy[i] = tvy[i];
      end
      cn = tn;
      padX = (st == lost) ? paddleHomeX : newPad;
      case (st)
         waitRelease: st = btnRelease ? inGame : waitRelease;
         inGame: st = ballLost ? lost : inGame;
         default: st = waitRelease;
      endcase
      if (st == inGame && (ballXPixel < gameBeginXPixel ||
         ballXPixel > gameEndXPixel - ballSizePixel)) begin
         failureCount++;
         $display("Ball went through a side wall at step %0d, x %0d", totalSteps, ballXPixel);
      end
      if (st == inGame && ballYPixel < pixelT'(ceilingYTile) * 10'd8 + 10'd8) begin
         failureCount++;
         $display("Ball went through the ceiling at step %0d, y %0d", totalSteps, ballYPixel);
      end
      if (hitBrick) begin
         frameHits++;
      end
   endtask

   task automatic compareSweep();
      int count;
      count = 0;
      for (int i = 0; i < brickCount; i++) begin
         count += image[i];
      end
      if (firstSweep) begin
         if (count != brickCount) begin
            mismatchCount++;
            $display("Mismatch bricks after reset: expected %0d, actual %0d", brickCount, count);
         end
      end else if (count > prevCount || prevCount - count < frameHits ||
         prevCount - count > 2 * frameHits) begin
         failureCount++;
         $display("Alive bricks went from %0d to %0d with %0d brick hits in the frame",
            prevCount, count, frameHits);
      end
      firstSweep = 1'b0;
      prevCount = count;
      frameHits = 0;
   endtask

   initial begin
      mismatchCount = 0;
      failureCount = 0;
   end

   always @(negedge CLK) begin
      if (RESET) begin
         cn = 1;
         cx[0] = {paddleHomeX[15:6] + (paddleLengthPixel - ballSizePixel) / 2, 6'd0};
         cy[0] = ballHomeY;
         cvx[0] = '0;
         cvy[0] = '0;
         padX = paddleHomeX;
         st = waitRelease;
         busy = 1'b0;
         totalSteps = 0;
         frameHits = 0;
         prevCount = brickCount;
         firstSweep = 1'b1;
         lastAddr = brickAddr;
      end else begin
         // Display data belongs to the address of the previous cycle.
         if (lastAddr < invalidBrick) begin
            image[lastAddr] = brickAlive;
         end
         lastAddr = brickAddr;
         if (!busy) begin
            if (stepComplete || hitWall || hitPaddle || hitBrick || ballLost ||
               hitBrickRow != 3'd0) begin
               failureCount++;
               $display("A control output is high while the core is idle");
            end
            if (startUpdate) begin
               busy = 1'b1;
               cyc = 0;
               stepNo = 0;
            end
         end else begin
            cyc++;
            if (stepComplete !== (cyc % 8 == 7)) begin
               failureCount++;
               $display("stepComplete is %b at cycle %0d of the frame", stepComplete, cyc);
            end
            if (stepComplete) begin
               checkStep();
               totalSteps++;
               stepNo++;
               if (stepNo == stepsPerFrame) begin
                  busy = 1'b0;
               end
            end
         end
         if (sweepDone) begin
            compareSweep();
         end
      end
   end

endmodule

/* test/gamePhysicsTb.sv */
module gamePhysicsTb;
   timeunit 1ns;
   timeprecision 1ps;
   import gamePhysicsPkg::*;

   localparam int frameCount = 400;
   localparam int frameTimeout = 200;

   logic CLK;
   logic RESET;
   logic startUpdate;
   logic btnLeft;
   logic btnRight;
   logic btnRelease;
   logic ignoreDeath;
   brickAddrT brickAddr;
   logic sweepDone;
   logic stepComplete;
   logic hitWall;
   logic hitPaddle;
   logic hitBrick;
   brickRowT hitBrickRow;
   logic ballLost;
   pixelT paddleXPixel;
   pixelT ballXPixel;
   pixelT ballYPixel;
   logic brickAlive;
   int seed;
   int mismatchCount;
   int failureCount;
   logic timedOut;

   initial CLK = 1'b0;
   always #4 CLK = ~CLK;

   gamePhysics u_gamePhysics (
      .CLK(CLK),
      .RESET(RESET),
      .startUpdate(startUpdate),
      .btnLeft(btnLeft),
      .btnRight(btnRight),
      .btnRelease(btnRelease),
      .ignoreDeath(ignoreDeath),
      .stepComplete(stepComplete),
      .hitWall(hitWall),
      .hitPaddle(hitPaddle),
      .hitBrick(hitBrick),
      .hitBrickRow(hitBrickRow),
      .ballLost(ballLost),
      .paddleXPixel(paddleXPixel),
      .ballXPixel(ballXPixel),
      .ballYPixel(ballYPixel),
      .brickAddr(brickAddr),
      .brickAlive(brickAlive)
   );

   physicsChecker u_physicsChecker (
      .CLK(CLK),
      .RESET(RESET),
      .startUpdate(startUpdate),
      .btnLeft(btnLeft),
      .btnRight(btnRight),
      .btnRelease(btnRelease),
      .ignoreDeath(ignoreDeath),
      .stepComplete(stepComplete),
      .hitWall(hitWall),
      .hitPaddle(hitPaddle),
      .hitBrick(hitBrick),
      .hitBrickRow(hitBrickRow),
      .ballLost(ballLost),
      .paddleXPixel(paddleXPixel),
      .ballXPixel(ballXPixel),
      .ballYPixel(ballYPixel),
      .brickAddr(brickAddr),
      .brickAlive(brickAlive),
      .sweepDone(sweepDone),
      .mismatchCount(mismatchCount),
      .failureCount(failureCount)
   );

   // Walk the display port over every brick.
   task automatic sweepBricks();
      for (int a = 0; a < brickCount; a++) begin
         @(posedge CLK);
         brickAddr <= brickAddrT'(a);
      end
      @(posedge CLK);
      sweepDone <= 1'b1;
      @(posedge CLK);
      sweepDone <= 1'b0;
   endtask

   // One frame with fresh buttons, then wait for all sub-steps.
   task automatic runFrame();
      int pulses;
      int waited;
      pulses = 0;
      waited = 0;
      @(posedge CLK);
      btnLeft <= (($random(seed) & 1) == 1);
      btnRight <= (($random(seed) & 1) == 1);
      btnRelease <= (($random(seed) & 7) == 0);
      ignoreDeath <= (($random(seed) & 3) == 0);
      startUpdate <= 1'b1;
      @(posedge CLK);
      startUpdate <= 1'b0;
      while (pulses < stepsPerFrame && waited < frameTimeout) begin
         @(posedge CLK);
         waited++;
         if (stepComplete) begin
            pulses++;
         end
      end
      if (pulses < stepsPerFrame) begin
         timedOut = 1'b1;
      end
   endtask

   initial begin
      seed = 32'haff2fe2e;
      timedOut = 1'b0;
      RESET = 1'b1;
      startUpdate = 1'b0;
      btnLeft = 1'b0;
      btnRight = 1'b0;
      btnRelease = 1'b0;
      ignoreDeath = 1'b0;
      brickAddr = '0;
      sweepDone = 1'b0;
      repeat (5) @(posedge CLK);
      RESET <= 1'b0;
      sweepBricks();
      for (int f = 0; f < frameCount && !timedOut; f++) begin
         runFrame();
         if (!timedOut) begin
            sweepBricks();
         end
      end
      @(posedge CLK);
      if (timedOut) begin
         $display("Timeout: a frame did not deliver all of its step pulses");
      end
      $display("Errors: %0d mismatches, %0d other failures, timeout %0d",
         mismatchCount, failureCount, timedOut);
      if (!timedOut && mismatchCount == 0 && failureCount == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* sources.f */
hw/gamePhysicsPkg.sv
hw/ballMotionIf.sv
hw/brickStore.sv
hw/stepSequencer.sv
hw/tileLocator.sv
hw/collisionResolver.sv
hw/ballPaddleState.sv
hw/gamePhysics.sv
test/physicsChecker.sv
test/gamePhysicsTb.sv
